/* rtl/control_unit.sv */
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module control_unit (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     ov,
    input  logic [`CTRL_OPCODE_W-1:0]                opcode,
    input  logic [`CTRL_FUNCT_W-1:0]                 funct,
    output logic                                     pc_write,
    output logic                                     mem_wr,
    output logic                                     ir_write,
    output logic                                     a_write,
    output logic                                     b_write,
    output logic                                     alu_out_write,
    output logic                                     epc_write,
    output logic                                     reg_write,
    output logic [$bits(ctrl_pkg::reg_dst_e)-1:0]    reg_dst,
    output logic [$bits(ctrl_pkg::exc_cause_e)-1:0]  except,
    output logic [$bits(ctrl_pkg::mem_size_e)-1:0]   mem_to_mdr,
    output logic [$bits(ctrl_pkg::mem_size_e)-1:0]   b_to_mem,
    output logic [$bits(ctrl_pkg::alu_src_a_e)-1:0]  alu_src_a,
    output logic [$bits(ctrl_pkg::iord_e)-1:0]       iord,
    output logic [$bits(ctrl_pkg::alu_src_b_e)-1:0]  alu_src_b,
    output logic [$bits(ctrl_pkg::alu_op_e)-1:0]     alu_op,
    output logic [$bits(ctrl_pkg::pc_src_e)-1:0]     pc_src,
    output logic [$bits(ctrl_pkg::mem_to_reg_e)-1:0] mem_to_reg
);

    ctrl_pkg::state_e state;

    decode_if dec_bus ();

    instr_decoder u_decoder (
        .opcode (opcode),
        .funct  (funct),
        .dec    (dec_bus.decoder)
    );

    ctrl_sequencer u_sequencer (
        .clk   (clk),
        .reset (reset),
        .ov    (ov),
        .dec   (dec_bus.sequencer),
        .state (state)
    );

    ctrl_signal_gen u_signal_gen (
        .state         (state),
        .ov            (ov),
        .dec           (dec_bus.signal_gen),
        .pc_write      (pc_write),
        .mem_wr        (mem_wr),
        .ir_write      (ir_write),
        .a_write       (a_write),
        .b_write       (b_write),
        .alu_out_write (alu_out_write),
        .epc_write     (epc_write),
        .reg_write     (reg_write),
        .reg_dst       (reg_dst),
        .except        (except),
        .mem_to_mdr    (mem_to_mdr),
        .b_to_mem      (b_to_mem),
        .alu_src_a     (alu_src_a),
        .iord          (iord),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .pc_src        (pc_src),
        .mem_to_reg    (mem_to_reg)
    );

endmodule

/* rtl/ctrl_defs.svh */
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// Instruction field widths
`define CTRL_OPCODE_W 6
`define CTRL_FUNCT_W 6

// Sequencer state encoding
`define CTRL_STATE_W 5

// Wait counter wide enough for the longest wait
`define CTRL_CNT_W 3

// Memory access latency during fetch
`define CTRL_FETCH_WAIT 2

// Exception vector read latency
`define CTRL_EXC_WAIT 3

`endif

/* rtl/ctrl_pkg.sv */
`include "ctrl_defs.svh"

package ctrl_pkg;

    typedef enum logic [`CTRL_STATE_W-1:0] {
        ST_STACK_INIT,
        ST_FETCH0,
        ST_FETCH1,
        ST_DECODE,
        ST_DISPATCH,
        ST_ALU_RR,
        ST_ALU_IMM,
        ST_WB_RD,
        ST_WB_RT,
        ST_LOAD,
        ST_STORE,
        ST_LUI,
        ST_EXC_ILLEGAL,
        ST_EXC_OVERFLOW,
        ST_EXC_VECTOR
    } state_e;

    typedef enum logic [`CTRL_OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_LUI   = 6'h0f,
        OP_LB    = 6'h20,
        OP_LH    = 6'h21,
        OP_LW    = 6'h23,
        OP_SB    = 6'h28,
        OP_SH    = 6'h29,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [`CTRL_FUNCT_W-1:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24
    } funct_e;

    typedef enum logic [2:0] {
        CL_ALU_RR,
        CL_ALU_IMM,
        CL_LOAD,
        CL_STORE,
        CL_LUI,
        CL_ILLEGAL
    } instr_class_e;

    typedef enum logic [2:0] {
        ALU_NONE = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_SUB  = 3'd3
    } alu_op_e;
    typedef enum logic [1:0] {SZ_WORD = 2'd0, SZ_HALF = 2'd1, SZ_BYTE = 2'd2} mem_size_e;
    typedef enum logic [1:0] {SRCA_PC = 2'd0, SRCA_REG_A = 2'd1} alu_src_a_e;
    typedef enum logic [2:0] {SRCB_REG_B = 3'd0, SRCB_FOUR = 3'd1, SRCB_IMM = 3'd2} alu_src_b_e;
    typedef enum logic [2:0] {ADDR_PC = 3'd0, ADDR_ALU_OUT = 3'd1, ADDR_EXC_VECTOR = 3'd2} iord_e;
    typedef enum logic [1:0] {DST_RT = 2'd0, DST_RD = 2'd1, DST_STACK_PTR = 2'd2} reg_dst_e;

    // Register file write-back source
    typedef enum logic [3:0] {
        WB_ALU_OUT   = 4'd0,
        WB_MDR       = 4'd1,
        WB_STACK_TOP = 4'd4,
        WB_LUI       = 4'd8
    } mem_to_reg_e;

    typedef enum logic [2:0] {PC_ALU = 3'd0, PC_EXC = 3'd3} pc_src_e;
    typedef enum logic [1:0] {EXC_ILLEGAL = 2'd0, EXC_OVERFLOW = 2'd1} exc_cause_e;

endpackage

/* rtl/ctrl_sequencer.sv */
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrl_sequencer (
    input  logic             clk,
    input  logic             reset,
    input  logic             ov,
    decode_if.sequencer      dec,
    output ctrl_pkg::state_e state
);

    localparam logic [`CTRL_CNT_W-1:0] FETCH_LAST = `CTRL_FETCH_WAIT - 1;
    localparam logic [`CTRL_CNT_W-1:0] EXC_LAST   = `CTRL_EXC_WAIT - 1;

    ctrl_pkg::state_e        state_next;
    logic [`CTRL_CNT_W-1:0]  wait_cnt;
    logic                    exc_wait;

    assign exc_wait = (state == ctrl_pkg::ST_EXC_ILLEGAL) ||
                      (state == ctrl_pkg::ST_EXC_OVERFLOW);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ctrl_pkg::ST_STACK_INIT;
            wait_cnt <= '0;
        end else begin
            state <= state_next;
            // Counts cycles spent in the current state
            if (state_next != state) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ctrl_pkg::ST_STACK_INIT: state_next = ctrl_pkg::ST_FETCH0;
            ctrl_pkg::ST_FETCH0: begin
                if (wait_cnt == FETCH_LAST) begin
                    state_next = ctrl_pkg::ST_FETCH1;
                end
            end
            ctrl_pkg::ST_FETCH1: state_next = ctrl_pkg::ST_DECODE;
            ctrl_pkg::ST_DECODE: state_next = ctrl_pkg::ST_DISPATCH;
            ctrl_pkg::ST_DISPATCH: begin
                case (dec.instr_class)
                    ctrl_pkg::CL_ALU_RR:  state_next = ctrl_pkg::ST_ALU_RR;
                    ctrl_pkg::CL_ALU_IMM: state_next = ctrl_pkg::ST_ALU_IMM;
                    ctrl_pkg::CL_LOAD:    state_next = ctrl_pkg::ST_LOAD;
                    ctrl_pkg::CL_STORE:   state_next = ctrl_pkg::ST_STORE;
                    ctrl_pkg::CL_LUI:     state_next = ctrl_pkg::ST_LUI;
                    default:              state_next = ctrl_pkg::ST_EXC_ILLEGAL;
                endcase
            end
            ctrl_pkg::ST_ALU_RR:  state_next = ctrl_pkg::ST_WB_RD;
            ctrl_pkg::ST_ALU_IMM: state_next = ctrl_pkg::ST_WB_RT;
            // Overflow flag is valid during write-back
            ctrl_pkg::ST_WB_RD, ctrl_pkg::ST_WB_RT: begin
                state_next = ov ? ctrl_pkg::ST_EXC_OVERFLOW : ctrl_pkg::ST_FETCH0;
            end
            ctrl_pkg::ST_LOAD, ctrl_pkg::ST_STORE, ctrl_pkg::ST_LUI: begin
                state_next = ctrl_pkg::ST_FETCH0;
            end
            ctrl_pkg::ST_EXC_ILLEGAL, ctrl_pkg::ST_EXC_OVERFLOW: begin
                if (wait_cnt == EXC_LAST) begin
                    state_next = ctrl_pkg::ST_EXC_VECTOR;
                end
            end
            ctrl_pkg::ST_EXC_VECTOR: state_next = ctrl_pkg::ST_FETCH0;
            default: state_next = ctrl_pkg::ST_STACK_INIT;
        endcase
    end

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {ctrl_pkg::ST_STACK_INIT, ctrl_pkg::ST_FETCH0, ctrl_pkg::ST_FETCH1,
                      ctrl_pkg::ST_DECODE, ctrl_pkg::ST_DISPATCH, ctrl_pkg::ST_ALU_RR,
                      ctrl_pkg::ST_ALU_IMM, ctrl_pkg::ST_WB_RD, ctrl_pkg::ST_WB_RT,
                      ctrl_pkg::ST_LOAD, ctrl_pkg::ST_STORE, ctrl_pkg::ST_LUI,
                      ctrl_pkg::ST_EXC_ILLEGAL, ctrl_pkg::ST_EXC_OVERFLOW,
                      ctrl_pkg::ST_EXC_VECTOR})
        else $error("sequencer state register holds an undefined encoding");

    a_dispatch_once: assert property (@(posedge clk) disable iff (reset)
        state == ctrl_pkg::ST_DISPATCH |=> state != ctrl_pkg::ST_DISPATCH)
        else $error("dispatch state held for more than one cycle");

    a_exc_wait_len: assert property (@(posedge clk) disable iff (reset)
        exc_wait [*`CTRL_EXC_WAIT] |=> !exc_wait)
        else $error("exception wait state exceeded its cycle count");

endmodule

/* rtl/ctrl_signal_gen.sv */
`timescale 1ns/1ps

module ctrl_signal_gen (
    input  ctrl_pkg::state_e      state,
    input  logic                  ov,
    decode_if.signal_gen          dec,
    output logic                  pc_write,
    output logic                  mem_wr,
    output logic                  ir_write,
    output logic                  a_write,
    output logic                  b_write,
    output logic                  alu_out_write,
    output logic                  epc_write,
    output logic                  reg_write,
    output ctrl_pkg::reg_dst_e    reg_dst,
    output ctrl_pkg::exc_cause_e  except,
    output ctrl_pkg::mem_size_e   mem_to_mdr,
    output ctrl_pkg::mem_size_e   b_to_mem,
    output ctrl_pkg::alu_src_a_e  alu_src_a,
    output ctrl_pkg::iord_e       iord,
    output ctrl_pkg::alu_src_b_e  alu_src_b,
    output ctrl_pkg::alu_op_e     alu_op,
    output ctrl_pkg::pc_src_e     pc_src,
    output ctrl_pkg::mem_to_reg_e mem_to_reg
);

    always_comb begin
        pc_write      = 1'b0;
        mem_wr        = 1'b0;
        ir_write      = 1'b0;
        a_write       = 1'b0;
        b_write       = 1'b0;
        alu_out_write = 1'b0;
        epc_write     = 1'b0;
        reg_write     = 1'b0;
        reg_dst       = ctrl_pkg::DST_RT;
        except        = ctrl_pkg::EXC_ILLEGAL;
        mem_to_mdr    = ctrl_pkg::SZ_WORD;
        b_to_mem      = ctrl_pkg::SZ_WORD;
        alu_src_a     = ctrl_pkg::SRCA_PC;
        iord          = ctrl_pkg::ADDR_PC;
        alu_src_b     = ctrl_pkg::SRCB_REG_B;
        alu_op        = ctrl_pkg::ALU_NONE;
        pc_src        = ctrl_pkg::PC_ALU;
        mem_to_reg    = ctrl_pkg::WB_ALU_OUT;

        case (state)
            // Instruction read while the ALU forms PC + 4
            ctrl_pkg::ST_FETCH0, ctrl_pkg::ST_FETCH1: begin
                iord      = ctrl_pkg::ADDR_PC;
                alu_src_a = ctrl_pkg::SRCA_PC;
                alu_src_b = ctrl_pkg::SRCB_FOUR;
                alu_op    = ctrl_pkg::ALU_ADD;
                if (state == ctrl_pkg::ST_FETCH1) begin
                    pc_write = 1'b1;
                    ir_write = 1'b1;
                end
            end
            ctrl_pkg::ST_DECODE: begin
                a_write = 1'b1;
                b_write = 1'b1;
            end
            ctrl_pkg::ST_ALU_RR, ctrl_pkg::ST_ALU_IMM: begin
                alu_src_a     = ctrl_pkg::SRCA_REG_A;
                alu_src_b     = (state == ctrl_pkg::ST_ALU_IMM) ? ctrl_pkg::SRCB_IMM
                                                                : ctrl_pkg::SRCB_REG_B;
                alu_op        = dec.alu_op;
                alu_out_write = 1'b1;
            end
            // Result is dropped on overflow
            ctrl_pkg::ST_WB_RD, ctrl_pkg::ST_WB_RT: begin
                if (!ov) begin
                    reg_write  = 1'b1;
                    reg_dst    = (state == ctrl_pkg::ST_WB_RD) ? ctrl_pkg::DST_RD
                                                               : ctrl_pkg::DST_RT;
                    mem_to_reg = ctrl_pkg::WB_ALU_OUT;
                end
            end
            ctrl_pkg::ST_LOAD: begin
                reg_write  = 1'b1;
                reg_dst    = ctrl_pkg::DST_RT;
                mem_to_reg = ctrl_pkg::WB_MDR;
                mem_to_mdr = dec.mem_size;
            end
            ctrl_pkg::ST_STORE: begin
                mem_wr   = 1'b1;
                iord     = ctrl_pkg::ADDR_ALU_OUT;
                b_to_mem = dec.mem_size;
            end
            ctrl_pkg::ST_LUI: begin
                reg_write  = 1'b1;
                reg_dst    = ctrl_pkg::DST_RT;
                mem_to_reg = ctrl_pkg::WB_LUI;
            end
            // Vector fetch while the ALU backs PC up by 4 for EPC
            ctrl_pkg::ST_EXC_ILLEGAL, ctrl_pkg::ST_EXC_OVERFLOW: begin
                except    = (state == ctrl_pkg::ST_EXC_OVERFLOW) ? ctrl_pkg::EXC_OVERFLOW
                                                                 : ctrl_pkg::EXC_ILLEGAL;
                iord      = ctrl_pkg::ADDR_EXC_VECTOR;
                alu_src_b = ctrl_pkg::SRCB_FOUR;
                alu_op    = ctrl_pkg::ALU_SUB;
            end
            ctrl_pkg::ST_EXC_VECTOR: begin
                epc_write = 1'b1;
                pc_write  = 1'b1;
                pc_src    = ctrl_pkg::PC_EXC;
            end
            ctrl_pkg::ST_STACK_INIT: begin
                reg_write  = 1'b1;
                reg_dst    = ctrl_pkg::DST_STACK_PTR;
                mem_to_reg = ctrl_pkg::WB_STACK_TOP;
            end
            default: ;
        endcase

        a_mem_reg_excl: assert final (!(mem_wr && reg_write))
            else $error("memory write and register write asserted together");
    end

endmodule

/* rtl/decode_if.sv */
`timescale 1ns/1ps

interface decode_if;

    ctrl_pkg::instr_class_e instr_class;
    ctrl_pkg::alu_op_e      alu_op;
    ctrl_pkg::mem_size_e    mem_size;
    // Immediate ALU ops write back to rt
    logic                   wb_to_rt;

    modport decoder (
        output instr_class,
        output alu_op,
        output mem_size,
        output wb_to_rt
    );

    modport sequencer (input instr_class);

    modport signal_gen (input alu_op, input mem_size);

endinterface

/* rtl/instr_decoder.sv */
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module instr_decoder (
    input  logic [`CTRL_OPCODE_W-1:0] opcode,
    input  logic [`CTRL_FUNCT_W-1:0]  funct,
    decode_if.decoder                 dec
);

    always_comb begin
        dec.instr_class = ctrl_pkg::CL_ILLEGAL;
        dec.alu_op      = ctrl_pkg::ALU_NONE;
        dec.mem_size    = ctrl_pkg::SZ_WORD;
        dec.wb_to_rt    = 1'b0;

        case (opcode)
            ctrl_pkg::OP_RTYPE: begin
                case (funct)
                    ctrl_pkg::FN_ADD: begin
                        dec.instr_class = ctrl_pkg::CL_ALU_RR;
                        dec.alu_op      = ctrl_pkg::ALU_ADD;
                    end
                    ctrl_pkg::FN_AND: begin
                        dec.instr_class = ctrl_pkg::CL_ALU_RR;
                        dec.alu_op      = ctrl_pkg::ALU_AND;
                    end
                    ctrl_pkg::FN_SUB: begin
                        dec.instr_class = ctrl_pkg::CL_ALU_RR;
                        dec.alu_op      = ctrl_pkg::ALU_SUB;
                    end
                    default: ;
                endcase
            end
            // addiu differs from addi only in the datapath overflow flag
            ctrl_pkg::OP_ADDI, ctrl_pkg::OP_ADDIU: begin
                dec.instr_class = ctrl_pkg::CL_ALU_IMM;
                dec.alu_op      = ctrl_pkg::ALU_ADD;
                dec.wb_to_rt    = 1'b1;
            end
            ctrl_pkg::OP_LW: dec.instr_class = ctrl_pkg::CL_LOAD;
            ctrl_pkg::OP_LH: begin
                dec.instr_class = ctrl_pkg::CL_LOAD;
                dec.mem_size    = ctrl_pkg::SZ_HALF;
            end
            ctrl_pkg::OP_LB: begin
                dec.instr_class = ctrl_pkg::CL_LOAD;
                dec.mem_size    = ctrl_pkg::SZ_BYTE;
            end
            ctrl_pkg::OP_SW: dec.instr_class = ctrl_pkg::CL_STORE;
            ctrl_pkg::OP_SH: begin
                dec.instr_class = ctrl_pkg::CL_STORE;
                dec.mem_size    = ctrl_pkg::SZ_HALF;
            end
            ctrl_pkg::OP_SB: begin
                dec.instr_class = ctrl_pkg::CL_STORE;
                dec.mem_size    = ctrl_pkg::SZ_BYTE;
            end
            ctrl_pkg::OP_LUI: dec.instr_class = ctrl_pkg::CL_LUI;
            default: ;
        endcase
    end

endmodule

/* tb.f */
+incdir+rtl
rtl/ctrl_pkg.sv
rtl/decode_if.sv
rtl/instr_decoder.sv
rtl/ctrl_sequencer.sv
rtl/ctrl_signal_gen.sv
rtl/control_unit.sv
verification/tb_control_unit.sv

/* verification/tb_control_unit.sv */
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module tb_control_unit;

    localparam int NUM_INSTR  = 300;
    localparam int CLK_PERIOD = 4;
    localparam int TIMEOUT_NS = (NUM_INSTR * 12 + 50) * CLK_PERIOD;

    logic       clk;
    logic       reset;
    logic       ov;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       pc_write, mem_wr, ir_write, a_write, b_write;
    logic       alu_out_write, epc_write, reg_write;
    logic [1:0] reg_dst, except, mem_to_mdr, b_to_mem, alu_src_a;
    logic [2:0] iord, alu_src_b, alu_op, pc_src;
    logic [3:0] mem_to_reg;

    // Reference model state
    ctrl_pkg::state_e       m_state;
    int                     m_cnt;
    ctrl_pkg::instr_class_e m_class;
    ctrl_pkg::alu_op_e      m_alu;
    ctrl_pkg::mem_size_e    m_size;

    // Expected control word
    logic e_pc_write, e_mem_wr, e_ir_write, e_a_write, e_b_write;
    logic e_alu_out_write, e_epc_write, e_reg_write;
    ctrl_pkg::reg_dst_e    e_reg_dst;
    ctrl_pkg::exc_cause_e  e_except;
    ctrl_pkg::mem_size_e   e_mem_to_mdr, e_b_to_mem;
    ctrl_pkg::alu_src_a_e  e_alu_src_a;
    ctrl_pkg::iord_e       e_iord;
    ctrl_pkg::alu_src_b_e  e_alu_src_b;
    ctrl_pkg::alu_op_e     e_alu_op;
    ctrl_pkg::pc_src_e     e_pc_src;
    ctrl_pkg::mem_to_reg_e e_mem_to_reg;

    logic [5:0] kept_ops [10];
    logic [5:0] kept_functs [3];
    int         n_instr;
    int         n_illegal;
    int         n_ov;
    int         cycle;
    int         last_ir;
    int         exp_len;
    bit         done;

    control_unit u_dut (
        .clk           (clk),
        .reset         (reset),
        .ov            (ov),
        .opcode        (opcode),
        .funct         (funct),
        .pc_write      (pc_write),
        .mem_wr        (mem_wr),
        .ir_write      (ir_write),
        .a_write       (a_write),
        .b_write       (b_write),
        .alu_out_write (alu_out_write),
        .epc_write     (epc_write),
        .reg_write     (reg_write),
        .reg_dst       (reg_dst),
        .except        (except),
        .mem_to_mdr    (mem_to_mdr),
        .b_to_mem      (b_to_mem),
        .alu_src_a     (alu_src_a),
        .iord          (iord),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .pc_src        (pc_src),
        .mem_to_reg    (mem_to_reg)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %0h, actual %0h", $time, name,
                     expected, actual);
            $display("Test FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic decode_model(input logic [5:0] op, input logic [5:0] fn);
        m_class = ctrl_pkg::CL_ILLEGAL;
        m_alu   = ctrl_pkg::ALU_NONE;
        m_size  = ctrl_pkg::SZ_WORD;
        case (op)
            ctrl_pkg::OP_RTYPE: begin
                m_class = ctrl_pkg::CL_ALU_RR;
                case (fn)
                    ctrl_pkg::FN_ADD: m_alu = ctrl_pkg::ALU_ADD;
                    ctrl_pkg::FN_AND: m_alu = ctrl_pkg::ALU_AND;
                    ctrl_pkg::FN_SUB: m_alu = ctrl_pkg::ALU_SUB;
                    default: m_class = ctrl_pkg::CL_ILLEGAL;
                endcase
            end
            ctrl_pkg::OP_ADDI, ctrl_pkg::OP_ADDIU: begin
                m_class = ctrl_pkg::CL_ALU_IMM;
                m_alu   = ctrl_pkg::ALU_ADD;
            end
            ctrl_pkg::OP_LW: m_class = ctrl_pkg::CL_LOAD;
            ctrl_pkg::OP_LH: begin
                m_class = ctrl_pkg::CL_LOAD;
                m_size  = ctrl_pkg::SZ_HALF;
            end
            ctrl_pkg::OP_LB: begin
                m_class = ctrl_pkg::CL_LOAD;
                m_size  = ctrl_pkg::SZ_BYTE;
            end
            ctrl_pkg::OP_SW: m_class = ctrl_pkg::CL_STORE;
            ctrl_pkg::OP_SH: begin
                m_class = ctrl_pkg::CL_STORE;
                m_size  = ctrl_pkg::SZ_HALF;
            end
            ctrl_pkg::OP_SB: begin
                m_class = ctrl_pkg::CL_STORE;
                m_size  = ctrl_pkg::SZ_BYTE;
            end
            ctrl_pkg::OP_LUI: m_class = ctrl_pkg::CL_LUI;
            default: ;
        endcase
    endtask

    // Mostly legal encodings with an arbitrary one now and then
    task automatic pick_instruction();
        if ($urandom_range(99) < 80) begin
            opcode = kept_ops[$urandom_range(9)];
        end else begin
            opcode = $urandom_range(63);
        end
        if (opcode == ctrl_pkg::OP_RTYPE && $urandom_range(99) < 80) begin
            funct = kept_functs[$urandom_range(2)];
        end else begin
            funct = $urandom_range(63);
        end
        decode_model(opcode, funct);
        if (m_class == ctrl_pkg::CL_ILLEGAL) begin
            n_illegal++;
        end
        n_instr++;
    endtask

    task automatic model_step();
        ctrl_pkg::state_e nxt;
        nxt = m_state;
        case (m_state)
            ctrl_pkg::ST_STACK_INIT: nxt = ctrl_pkg::ST_FETCH0;
            ctrl_pkg::ST_FETCH0: begin
                if (m_cnt == `CTRL_FETCH_WAIT - 1) begin
                    nxt = ctrl_pkg::ST_FETCH1;
                end
            end
            ctrl_pkg::ST_FETCH1: nxt = ctrl_pkg::ST_DECODE;
            ctrl_pkg::ST_DECODE: nxt = ctrl_pkg::ST_DISPATCH;
            ctrl_pkg::ST_DISPATCH: begin
                case (m_class)
                    ctrl_pkg::CL_ALU_RR:  nxt = ctrl_pkg::ST_ALU_RR;
                    ctrl_pkg::CL_ALU_IMM: nxt = ctrl_pkg::ST_ALU_IMM;
                    ctrl_pkg::CL_LOAD:    nxt = ctrl_pkg::ST_LOAD;
                    ctrl_pkg::CL_STORE:   nxt = ctrl_pkg::ST_STORE;
                    ctrl_pkg::CL_LUI:     nxt = ctrl_pkg::ST_LUI;
                    default:              nxt = ctrl_pkg::ST_EXC_ILLEGAL;
                endcase
                if (m_class == ctrl_pkg::CL_ALU_RR || m_class == ctrl_pkg::CL_ALU_IMM) begin
                    exp_len += 2;
                end else if (m_class == ctrl_pkg::CL_ILLEGAL) begin
                    exp_len += `CTRL_EXC_WAIT + 1;
                end else begin
                    exp_len += 1;
                end
            end
            ctrl_pkg::ST_ALU_RR:  nxt = ctrl_pkg::ST_WB_RD;
            ctrl_pkg::ST_ALU_IMM: nxt = ctrl_pkg::ST_WB_RT;
            ctrl_pkg::ST_WB_RD, ctrl_pkg::ST_WB_RT: begin
                nxt = ctrl_pkg::ST_FETCH0;
                if (ov) begin
                    nxt = ctrl_pkg::ST_EXC_OVERFLOW;
                    exp_len += `CTRL_EXC_WAIT + 1;
                    n_ov++;
                end
            end
            ctrl_pkg::ST_EXC_ILLEGAL, ctrl_pkg::ST_EXC_OVERFLOW: begin
                if (m_cnt == `CTRL_EXC_WAIT - 1) begin
                    nxt = ctrl_pkg::ST_EXC_VECTOR;
                end
            end
            default: nxt = ctrl_pkg::ST_FETCH0;
        endcase
        m_cnt   = (nxt == m_state) ? m_cnt + 1 : 0;
        m_state = nxt;
        cycle++;
    endtask

    task automatic check_outputs();
        e_pc_write      = 1'b0;
        e_mem_wr        = 1'b0;
        e_ir_write      = 1'b0;
        e_a_write       = 1'b0;
        e_b_write       = 1'b0;
        e_alu_out_write = 1'b0;
        e_epc_write     = 1'b0;
        e_reg_write     = 1'b0;
        e_reg_dst       = ctrl_pkg::DST_RT;
        e_except        = ctrl_pkg::EXC_ILLEGAL;
        e_mem_to_mdr    = ctrl_pkg::SZ_WORD;
        e_b_to_mem      = ctrl_pkg::SZ_WORD;
        e_alu_src_a     = ctrl_pkg::SRCA_PC;
        e_iord          = ctrl_pkg::ADDR_PC;
        e_alu_src_b     = ctrl_pkg::SRCB_REG_B;
        e_alu_op        = ctrl_pkg::ALU_NONE;
        e_pc_src        = ctrl_pkg::PC_ALU;
        e_mem_to_reg    = ctrl_pkg::WB_ALU_OUT;
        case (m_state)
            ctrl_pkg::ST_FETCH0, ctrl_pkg::ST_FETCH1: begin
                e_alu_src_b = ctrl_pkg::SRCB_FOUR;
                e_alu_op    = ctrl_pkg::ALU_ADD;
                e_pc_write  = (m_state == ctrl_pkg::ST_FETCH1);
                e_ir_write  = (m_state == ctrl_pkg::ST_FETCH1);
            end
            ctrl_pkg::ST_DECODE: begin
                e_a_write = 1'b1;
                e_b_write = 1'b1;
            end
            ctrl_pkg::ST_ALU_RR: begin
                e_alu_src_a     = ctrl_pkg::SRCA_REG_A;
                e_alu_op        = m_alu;
                e_alu_out_write = 1'b1;
            end
            ctrl_pkg::ST_ALU_IMM: begin
                e_alu_src_a     = ctrl_pkg::SRCA_REG_A;
                e_alu_src_b     = ctrl_pkg::SRCB_IMM;
                e_alu_op        = m_alu;
                e_alu_out_write = 1'b1;
            end
            ctrl_pkg::ST_WB_RD: begin
                e_reg_write = !ov;
                e_reg_dst   = ov ? ctrl_pkg::DST_RT : ctrl_pkg::DST_RD;
            end
            ctrl_pkg::ST_WB_RT: e_reg_write = !ov;
            ctrl_pkg::ST_LOAD: begin
                e_reg_write  = 1'b1;
                e_mem_to_reg = ctrl_pkg::WB_MDR;
                e_mem_to_mdr = m_size;
            end
            ctrl_pkg::ST_STORE: begin
                e_mem_wr   = 1'b1;
                e_iord     = ctrl_pkg::ADDR_ALU_OUT;
                e_b_to_mem = m_size;
            end
            ctrl_pkg::ST_LUI: begin
                e_reg_write  = 1'b1;
                e_mem_to_reg = ctrl_pkg::WB_LUI;
            end
            ctrl_pkg::ST_EXC_ILLEGAL, ctrl_pkg::ST_EXC_OVERFLOW: begin
                if (m_state == ctrl_pkg::ST_EXC_OVERFLOW) begin
                    e_except = ctrl_pkg::EXC_OVERFLOW;
                end
                e_iord      = ctrl_pkg::ADDR_EXC_VECTOR;
                e_alu_src_b = ctrl_pkg::SRCB_FOUR;
                e_alu_op    = ctrl_pkg::ALU_SUB;
            end
            ctrl_pkg::ST_EXC_VECTOR: begin
                e_epc_write = 1'b1;
                e_pc_write  = 1'b1;
                e_pc_src    = ctrl_pkg::PC_EXC;
            end
            ctrl_pkg::ST_STACK_INIT: begin
                e_reg_write  = 1'b1;
                e_reg_dst    = ctrl_pkg::DST_STACK_PTR;
                e_mem_to_reg = ctrl_pkg::WB_STACK_TOP;
            end
            default: ;
        endcase
        check_value("pc_write", e_pc_write, pc_write);
        check_value("mem_wr", e_mem_wr, mem_wr);
        check_value("ir_write", e_ir_write, ir_write);
        check_value("a_write", e_a_write, a_write);
        check_value("b_write", e_b_write, b_write);
        check_value("alu_out_write", e_alu_out_write, alu_out_write);
        check_value("epc_write", e_epc_write, epc_write);
        check_value("reg_write", e_reg_write, reg_write);
        check_value("reg_dst", e_reg_dst, reg_dst);
        check_value("except", e_except, except);
        check_value("mem_to_mdr", e_mem_to_mdr, mem_to_mdr);
        check_value("b_to_mem", e_b_to_mem, b_to_mem);
        check_value("alu_src_a", e_alu_src_a, alu_src_a);
        check_value("iord", e_iord, iord);
        check_value("alu_src_b", e_alu_src_b, alu_src_b);
        check_value("alu_op", e_alu_op, alu_op);
        check_value("pc_src", e_pc_src, pc_src);
        check_value("mem_to_reg", e_mem_to_reg, mem_to_reg);
        // Instruction length measured between fetches
        if (ir_write) begin
            if (last_ir >= 0) begin
                check_value("ir_write interval", exp_len, cycle - last_ir);
            end
            last_ir = cycle;
            exp_len = `CTRL_FETCH_WAIT + 3;
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        ov          = 1'b0;
        opcode      = '0;
        funct       = '0;
        void'($urandom(28847));
        kept_ops    = '{ctrl_pkg::OP_RTYPE, ctrl_pkg::OP_ADDI, ctrl_pkg::OP_ADDIU,
                        ctrl_pkg::OP_LUI, ctrl_pkg::OP_LB, ctrl_pkg::OP_LH, ctrl_pkg::OP_LW,
                        ctrl_pkg::OP_SB, ctrl_pkg::OP_SH, ctrl_pkg::OP_SW};
        kept_functs = '{ctrl_pkg::FN_ADD, ctrl_pkg::FN_SUB, ctrl_pkg::FN_AND};
        m_state     = ctrl_pkg::ST_STACK_INIT;
        m_cnt       = 0;
        n_instr     = 0;
        n_illegal   = 0;
        n_ov        = 0;
        cycle       = 0;
        last_ir     = -1;
        exp_len     = 0;
        done        = 1'b0;
        decode_model(opcode, funct);

        // Three rising edges with reset high
        repeat (3) @(negedge clk);
        reset = 1'b0;
        while (!done) begin
            if (m_state == ctrl_pkg::ST_FETCH0 && m_cnt == 0) begin
                if (n_instr == NUM_INSTR) begin
                    done = 1'b1;
                end else begin
                    pick_instruction();
                end
            end
            if (!done) begin
                ov = ($urandom_range(4) == 0);
                #1;
                check_outputs();
                @(posedge clk);
                model_step();
                @(negedge clk);
            end
        end

        if (n_ov == 0 || n_illegal == 0) begin
            $display("Random stimulus never reached the overflow or illegal path");
            $display("Test FAILED");
            $fatal(1, "coverage hole");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule
